//--- Bender.yml
package:
  name: exe_mem_stage

sources:
  - files:
      - logic/exe_pkg.sv
      - logic/store_format.sv
      - logic/tlb_lookup.sv
      - logic/exe_mem_stage.sv
  - target: test
    files:
      - tb/exe_mem_stage_tb.sv

//--- exe_mem_stage.f
logic/exe_pkg.sv
logic/store_format.sv
logic/tlb_lookup.sv
logic/exe_mem_stage.sv
tb/exe_mem_stage_tb.sv

//--- logic/exe_mem_stage.sv
`timescale 1ns/1ps

module exe_mem_stage import exe_pkg::*; (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      flush,
    // from decode
    input  logic                      in_valid,
    output logic                      allowin,
    input  ls_op_t                    op,
    input  addr_t                     base,
    input  logic [15:0]               imm,
    input  addr_t                     rt_value,
    input  logic [dest_w-1:0]         dest,
    input  addr_t                     pc,
    // to memory stage
    input  logic                      ms_allowin,
    output logic                      out_valid,
    output addr_t                     out_pc,
    output logic [dest_w-1:0]         out_dest,
    output ls_op_t                    out_op,
    output logic [1:0]                out_offset,
    output logic                      out_has_exception,
    output exc_code_t                 out_exc_code,
    output addr_t                     out_badvaddr,
    output logic                      out_tlb_refill,
    // data cache
    output logic                      dc_valid,
    output logic                      dc_op,
    output logic                      dc_uncache,
    output logic [cache_tag_w-1:0]    dc_tag,
    output logic [cache_index_w-1:0]  dc_index,
    output logic [cache_offset_w-1:0] dc_offset,
    output size_t                     dc_size,
    output strb_t                     dc_wstrb,
    output addr_t                     dc_wdata,
    input  logic                      dc_addr_ok,
    // TLB search port
    output vpn2_t                     s1_vpn2,
    output logic                      s1_odd_page,
    output asid_t                     s1_asid,
    input  logic                      s1_found,
    input  pfn_t                      s1_pfn,
    input  logic                      s1_v,
    input  logic                      s1_d,
    input  asid_t                     entryhi_asid,
    input  logic                      tlb_write
);

    logic              es_valid;
    ls_op_t            es_op;
    addr_t             es_base;
    logic [15:0]       es_imm;
    addr_t             es_rt;
    logic [dest_w-1:0] es_dest;
    addr_t             es_pc;

    addr_t ea;
    addr_t va;
    addr_t pa;
    logic  is_load;
    logic  adel;
    logic  ades;
    logic  req_en;
    logic  refill;
    logic  invalid;
    logic  modified;
    logic  has_exception;
    logic  dc_accept;
    logic  ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            es_valid <= 1'b0;
        end else if (flush) begin
            es_valid <= 1'b0;
        end else if (allowin) begin
            es_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && allowin) begin
            es_op   <= op;
            es_base <= base;
            es_imm  <= imm;
            es_rt   <= rt_value;
            es_dest <= dest;
            es_pc   <= pc;
        end
    end

    assign is_load = (es_op <= op_lwr);
    assign ea      = es_base + {{16{es_imm[15]}}, es_imm};
    // lwl/swl go out on the word address
    assign va      = (es_op == op_lwl || es_op == op_swl) ? {ea[xlen-1:2], 2'b00} : ea;

    store_format u_store_format (
        .op       (es_op),
        .offset   (ea[1:0]),
        .rt_value (es_rt),
        .is_load  (is_load),
        .wstrb    (dc_wstrb),
        .size     (dc_size),
        .wdata    (dc_wdata),
        .adel     (adel),
        .ades     (ades)
    );

    tlb_lookup u_tlb_lookup (
        .clk          (clk),
        .reset        (reset),
        .va           (va),
        .busy         (es_valid && !adel && !ades && !flush),
        .is_store     (!is_load),
        .dc_addr_ok   (dc_accept),
        .tlb_write    (tlb_write),
        .entryhi_asid (entryhi_asid),
        .s1_found     (s1_found),
        .s1_pfn       (s1_pfn),
        .s1_v         (s1_v),
        .s1_d         (s1_d),
        .s1_vpn2      (s1_vpn2),
        .s1_odd_page  (s1_odd_page),
        .s1_asid      (s1_asid),
        .pa           (pa),
        .req_en       (req_en),
        .refill       (refill),
        .invalid      (invalid),
        .modified     (modified)
    );

    assign has_exception = adel | ades | refill | invalid | modified;

    // downstream back-pressure holds the request
    assign dc_valid   = es_valid && !flush && !has_exception && req_en && ms_allowin;
    assign dc_accept  = dc_valid && dc_addr_ok;
    assign dc_op      = ~is_load;
    assign dc_uncache = (va[xlen-1:xlen-3] == 3'b101); // kseg1
    assign dc_tag     = pa[xlen-1 -: cache_tag_w];
    assign dc_index   = pa[cache_offset_w +: cache_index_w];
    assign dc_offset  = pa[cache_offset_w-1:0];

    assign ready   = has_exception || dc_accept;
    assign allowin = !es_valid || (ready && ms_allowin);

    assign out_valid         = es_valid && ready && !flush;
    assign out_pc            = es_pc;
    assign out_dest          = es_dest;
    assign out_op            = es_op;
    assign out_offset        = ea[1:0];
    assign out_has_exception = has_exception;
    assign out_badvaddr      = va;
    assign out_tlb_refill    = refill;

    always_comb begin
        if (adel) begin
            out_exc_code = exc_adel;
        end else if (ades) begin
            out_exc_code = exc_ades;
        end else if (refill || invalid) begin
            out_exc_code = is_load ? exc_tlbl : exc_tlbs;
        end else begin
            out_exc_code = exc_mod; // only meaningful with out_has_exception
        end
    end

endmodule

//--- logic/exe_pkg.sv
package exe_pkg;

    localparam int xlen          = 32;
    localparam int vpn2_w        = 19;
    localparam int pfn_w         = 20;
    localparam int asid_w        = 8;
    localparam int dest_w        = 5;
    localparam int page_offset_w = 12;

    // physical address split for the data cache
    localparam int cache_tag_w    = 20;
    localparam int cache_index_w  = 8;
    localparam int cache_offset_w = 4;

    typedef logic [xlen-1:0]   addr_t;
    typedef logic [vpn2_w-1:0] vpn2_t;
    typedef logic [pfn_w-1:0]  pfn_t;
    typedef logic [asid_w-1:0] asid_t;
    typedef logic [3:0]        strb_t;
    typedef logic [1:0]        size_t;

    localparam size_t size_byte = 2'd0;
    localparam size_t size_half = 2'd1;
    localparam size_t size_word = 2'd2;

    // loads first, so op <= op_lwr means load
    typedef enum logic [3:0] {
        op_lb, op_lbu, op_lh, op_lhu, op_lw, op_lwl, op_lwr,
        op_sb, op_sh, op_sw, op_swl, op_swr
    } ls_op_t;

    typedef logic [4:0] exc_code_t;

    localparam exc_code_t exc_mod  = 5'd1;
    localparam exc_code_t exc_tlbl = 5'd2;
    localparam exc_code_t exc_tlbs = 5'd3;
    localparam exc_code_t exc_adel = 5'd4;
    localparam exc_code_t exc_ades = 5'd5;

endpackage

//--- logic/store_format.sv
`timescale 1ns/1ps

module store_format import exe_pkg::*; (
    input  ls_op_t     op,
    input  logic [1:0] offset,
    input  addr_t      rt_value,
    input  logic       is_load,
    output strb_t      wstrb,
    output size_t      size,
    output addr_t      wdata,
    output logic       adel,
    output logic       ades
);

    strb_t strb_raw;
    logic  misaligned;

    always_comb begin
        strb_raw   = 4'b0000;
        size       = size_word;
        wdata      = rt_value;
        misaligned = 1'b0;
        case (op)
            op_lb, op_lbu, op_sb: begin
                strb_raw = 4'b0001 << offset;
                size     = size_byte;
                wdata    = {4{rt_value[7:0]}}; // byte copied to every lane
            end
            op_lh, op_lhu, op_sh: begin
                strb_raw   = offset[1] ? 4'b1100 : 4'b0011;
                size       = size_half;
                wdata      = {2{rt_value[15:0]}};
                misaligned = offset[0];
            end
            op_lw, op_sw: begin
                strb_raw   = 4'b1111;
                misaligned = |offset;
            end
            op_lwl, op_swl: begin
                // left part fills lanes 0..offset from the top of rt
                strb_raw = 4'b1111 >> (2'd3 - offset);
                if (offset == 2'd0) begin
                    size = size_byte;
                end else if (offset == 2'd1) begin
                    size = size_half;
                end else begin
                    size = size_word;
                end
                wdata = rt_value >> {(2'd3 - offset), 3'b000};
            end
            op_lwr, op_swr: begin
                strb_raw = 4'b1111 << offset; // lanes offset..3
                if (offset == 2'd3) begin
                    size = size_byte;
                end else if (offset == 2'd2) begin
                    size = size_half;
                end else begin
                    size = size_word;
                end
                wdata = rt_value << {offset, 3'b000};
            end
            default: ;
        endcase
    end

    assign wstrb = is_load ? strb_t'(0) : strb_raw;
    assign adel  = is_load & misaligned;
    assign ades  = ~is_load & misaligned;

endmodule

//--- logic/tlb_lookup.sv
`timescale 1ns/1ps

module tlb_lookup import exe_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  addr_t va,
    input  logic  busy,
    input  logic  is_store,
    input  logic  dc_addr_ok,
    input  logic  tlb_write,
    input  asid_t entryhi_asid,
    input  logic  s1_found,
    input  pfn_t  s1_pfn,
    input  logic  s1_v,
    input  logic  s1_d,
    output vpn2_t s1_vpn2,
    output logic  s1_odd_page,
    output asid_t s1_asid,
    output addr_t pa,
    output logic  req_en,
    output logic  refill,
    output logic  invalid,
    output logic  modified
);

    typedef enum logic [1:0] {st_idle, st_lookup, st_request} state_t;

    state_t state;
    state_t next_state;

    // the single cached translation
    vpn2_t ent_vpn2;
    logic  ent_odd;
    pfn_t  ent_pfn;
    logic  ent_v;
    logic  ent_d;
    logic  ent_found;
    logic  ent_valid;

    logic mapped;
    logic hit;
    logic tlb_exc;

    assign mapped = (va[xlen-1:xlen-2] != 2'b10); // kseg0/kseg1 bypass the TLB

    // only a usable translation counts as a hit, faulting ones go back to the TLB
    assign hit = ent_valid && ent_vpn2 == va[xlen-1 -: vpn2_w] && ent_odd == va[page_offset_w]
                 && ent_found && ent_v && (!is_store || ent_d);

    assign refill   = (state == st_request) & ~ent_found;
    assign invalid  = (state == st_request) & ent_found & ~ent_v;
    assign modified = (state == st_request) & is_store & ent_found & ent_v & ~ent_d;
    assign tlb_exc  = refill | invalid | modified;

    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                if (busy && mapped && !hit) begin
                    next_state = st_lookup;
                end
            end
            st_lookup: begin
                next_state = busy ? st_request : st_idle;
            end
            st_request: begin
                if (!busy || dc_addr_ok || tlb_exc) begin
                    next_state = st_idle;
                end
            end
            default: next_state = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ent_valid <= 1'b0;
        end else if (tlb_write) begin
            ent_valid <= 1'b0; // TLB contents changed
        end else if (state == st_lookup) begin
            ent_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_lookup) begin
            ent_vpn2  <= va[xlen-1 -: vpn2_w];
            ent_odd   <= va[page_offset_w];
            ent_pfn   <= s1_pfn;
            ent_v     <= s1_v;
            ent_d     <= s1_d;
            ent_found <= s1_found;
        end
    end

    assign s1_vpn2     = va[xlen-1 -: vpn2_w];
    assign s1_odd_page = va[page_offset_w];
    assign s1_asid     = entryhi_asid;

    assign pa = mapped ? {ent_pfn, va[page_offset_w-1:0]} : {3'b000, va[xlen-4:0]};

    assign req_en = (state == st_idle && (!mapped || hit)) || (state == st_request && !tlb_exc);

endmodule

//--- tb/exe_mem_stage_stimulus.txt
// twr op base imm rt dest pc found pfn v d | tag index offset size strb wdata exc code refill
// op: lb0 lbu1 lh2 lhu3 lw4 lwl5 lwr6 sb7 sh8 sw9 swla swrb, wdata checked for stores only
0 9 80001000 0004 11223344 01 bfc00000 0 00000 0 0 00001 00 4 2 f 11223344 0 0 0
0 4 80001000 0004 11223344 02 bfc00004 0 00000 0 0 00001 00 4 2 0 00000000 0 0 0
0 7 a0002000 0013 11223344 03 bfc00008 0 00000 0 0 00002 01 3 0 8 44444444 0 0 0
0 1 a0002000 0013 11223344 04 bfc0000c 0 00000 0 0 00002 01 3 0 0 00000000 0 0 0
0 8 80000100 0022 11223344 05 bfc00010 0 00000 0 0 00000 12 2 1 c 33443344 0 0 0
0 2 80000100 fffe 11223344 06 bfc00014 0 00000 0 0 00000 0f e 1 0 00000000 0 0 0
0 7 80000ff0 0001 11223344 07 bfc00018 0 00000 0 0 00000 ff 1 0 2 44444444 0 0 0
0 a 80003000 0000 11223344 08 bfc0001c 0 00000 0 0 00003 00 0 0 1 00000011 0 0 0
0 a 80003000 0001 11223344 09 bfc00020 0 00000 0 0 00003 00 0 1 3 00001122 0 0 0
0 a 80003000 0002 11223344 0a bfc00024 0 00000 0 0 00003 00 0 2 7 00112233 0 0 0
0 a 80003000 0003 11223344 0b bfc00028 0 00000 0 0 00003 00 0 2 f 11223344 0 0 0
0 b 80003000 0000 11223344 0c bfc0002c 0 00000 0 0 00003 00 0 2 f 11223344 0 0 0
0 b 80003000 0001 11223344 0d bfc00030 0 00000 0 0 00003 00 1 2 e 22334400 0 0 0
0 b 80003000 0002 11223344 0e bfc00034 0 00000 0 0 00003 00 2 1 c 33440000 0 0 0
0 b 80003000 0003 11223344 0f bfc00038 0 00000 0 0 00003 00 3 0 8 44000000 0 0 0
0 5 80003000 0002 11223344 10 bfc0003c 0 00000 0 0 00003 00 0 2 0 00000000 0 0 0
0 6 80003000 0003 11223344 11 bfc00040 0 00000 0 0 00003 00 3 0 0 00000000 0 0 0
0 2 80000000 0001 11223344 12 bfc00044 0 00000 0 0 00000 00 0 0 0 00000000 1 4 0
0 4 80000000 0002 11223344 13 bfc00048 0 00000 0 0 00000 00 0 0 0 00000000 1 4 0
0 8 80000000 0003 11223344 14 bfc0004c 0 00000 0 0 00000 00 0 0 0 00000000 1 5 0
0 9 80000000 0001 11223344 15 bfc00050 0 00000 0 0 00000 00 0 0 0 00000000 1 5 0
0 3 80000000 0005 11223344 16 bfc00054 0 00000 0 0 00000 00 0 0 0 00000000 1 4 0
0 4 00400000 0010 11223344 17 bfc00058 1 12345 1 1 12345 01 0 2 0 00000000 0 0 0
0 4 00400000 0024 11223344 18 bfc0005c 1 55555 1 1 12345 02 4 2 0 00000000 0 0 0
0 9 00400000 0100 11223344 19 bfc00060 1 55555 1 1 12345 10 0 2 f 11223344 0 0 0
1 4 00400000 0030 11223344 1a bfc00064 1 55555 1 1 55555 03 0 2 0 00000000 0 0 0
0 4 00401000 0008 11223344 1b bfc00068 1 0abcd 1 1 0abcd 00 8 2 0 00000000 0 0 0
0 4 00800000 0000 11223344 1c bfc0006c 0 00000 0 0 00000 00 0 0 0 00000000 1 2 1
0 9 00800000 0004 11223344 1d bfc00070 0 00000 0 0 00000 00 0 0 0 00000000 1 3 1
0 4 00802000 0000 11223344 1e bfc00074 1 00abc 0 0 00000 00 0 0 0 00000000 1 2 0
0 7 00802000 0001 11223344 1f bfc00078 1 00abc 0 0 00000 00 0 0 0 00000000 1 3 0
0 9 00804000 0008 11223344 01 bfc0007c 1 00777 1 0 00000 00 0 0 0 00000000 1 1 0
0 4 00804000 000c 11223344 02 bfc00080 1 00777 1 0 00777 00 c 2 0 00000000 0 0 0
0 9 80000400 0008 11223344 03 bfc00084 0 00000 0 0 00000 40 8 2 f 11223344 0 0 0
0 8 a0000400 000a 11223344 04 bfc00088 0 00000 0 0 00000 40 a 1 c 33443344 0 0 0
0 1 80000400 0007 11223344 05 bfc0008c 0 00000 0 0 00000 40 7 0 0 00000000 0 0 0

//--- tb/exe_mem_stage_tb.sv
`timescale 1ns/1ps

module exe_mem_stage_tb import exe_pkg::*; ();

    localparam int    max_lines       = 64;
    localparam int    nf              = 20;
    localparam int    cycles_per_line = 40;
    localparam int    wd_slack        = 20;
    localparam string stim_path       = "tb/exe_mem_stage_stimulus.txt";

    // columns of one stimulus line
    localparam int c_twr = 0, c_op = 1, c_base = 2, c_imm = 3, c_rt = 4, c_dest = 5;
    localparam int c_pc = 6, c_found = 7, c_pfn = 8, c_v = 9, c_d = 10, c_tag = 11;
    localparam int c_index = 12, c_offset = 13, c_size = 14, c_strb = 15, c_wdata = 16;
    localparam int c_exc = 17, c_code = 18, c_refill = 19;

    logic clk = 1'b0;
    logic reset = 1'b1;
    logic flush = 1'b0;
    logic in_valid = 1'b0;
    logic allowin;
    ls_op_t op = op_lw;
    addr_t base = '0;
    logic [15:0] imm = '0;
    addr_t rt_value = '0;
    logic [dest_w-1:0] dest = '0;
    addr_t pc = '0;
    logic ms_allowin = 1'b1;
    logic out_valid, out_has_exception, out_tlb_refill;
    addr_t out_pc, out_badvaddr;
    logic [dest_w-1:0] out_dest;
    ls_op_t out_op;
    logic [1:0] out_offset;
    exc_code_t out_exc_code;
    logic dc_valid, dc_op, dc_uncache;
    logic [cache_tag_w-1:0] dc_tag;
    logic [cache_index_w-1:0] dc_index;
    logic [cache_offset_w-1:0] dc_offset;
    size_t dc_size;
    strb_t dc_wstrb;
    addr_t dc_wdata;
    logic dc_addr_ok = 1'b0;
    vpn2_t s1_vpn2;
    logic s1_odd_page;
    asid_t s1_asid;
    logic s1_found = 1'b0;
    pfn_t s1_pfn = '0;
    logic s1_v = 1'b0;
    logic s1_d = 1'b0;
    asid_t entryhi_asid = '0;
    logic tlb_write = 1'b0;

    logic [31:0] stim [0:max_lines*nf-1];
    integer seed = 32'h41e4;
    int n_lines = 0;
    int cur = 0;
    int done_count = 0;
    int errors = 0;
    int ok_wait = 0;
    logic req_seen = 1'b0;
    logic req_taken = 1'b0;
    logic just_accepted = 1'b0;

    exe_mem_stage dut_i (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] field(int k);
        return stim[cur*nf + k];
    endfunction

    // base plus sign-extended imm
    function automatic addr_t exp_ea();
        logic [31:0] ofs;
        ofs = field(c_imm);
        return field(c_base) + {{16{ofs[15]}}, ofs[15:0]};
    endfunction

    // lwl and swl use the word address
    function automatic addr_t exp_va();
        addr_t ea;
        ea = exp_ea();
        if (field(c_op) == 32'h5 || field(c_op) == 32'ha) begin
            ea[1:0] = 2'b00;
        end
        return ea;
    endfunction

    task automatic stop_on_error(string msg);
        errors++;
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_word(string name, addr_t exp, addr_t act);
        if (exp !== act) begin
            stop_on_error($sformatf("** Error at %0t: %s expected %h, got %h",
                                    $time, name, exp, act));
        end
    endtask

    task automatic check_strb(string name, strb_t exp, strb_t act);
        if (exp !== act) begin
            stop_on_error($sformatf("** Error at %0t: %s expected %h, got %h",
                                    $time, name, exp, act));
        end
    endtask

    task automatic check_size(string name, size_t exp, size_t act);
        if (exp !== act) begin
            stop_on_error($sformatf("** Error at %0t: %s expected %h, got %h",
                                    $time, name, exp, act));
        end
    endtask

    task automatic check_exc(string name, exc_code_t exp, exc_code_t act);
        if (exp !== act) begin
            stop_on_error($sformatf("** Error at %0t: %s expected %h, got %h",
                                    $time, name, exp, act));
        end
    endtask

    // sample where outputs are settled
    always @(negedge clk) begin
        req_taken <= 1'b0;
        just_accepted <= in_valid && allowin;
        if (!reset) begin
            if (dc_valid && !ms_allowin) begin
                stop_on_error("dc_valid raised while ms_allowin was low");
            end
            if (just_accepted && field(c_exc) == 0 && exp_va() >> 30 == 32'h2
                && ms_allowin && !dc_valid) begin
                stop_on_error("unmapped access did not request the cache at once");
            end
            if (just_accepted && field(c_exc) != 0 && !out_valid
                && (field(c_code) == 32'h4 || field(c_code) == 32'h5)) begin
                stop_on_error("address error did not finish right after acceptance");
            end
            if (dc_valid && dc_addr_ok) begin
                req_taken <= 1'b1;
                if (field(c_exc) != 0) begin
                    stop_on_error("cache request issued for a faulting instruction");
                end
                req_seen = 1'b1;
                check_word("dc_tag", addr_t'(field(c_tag)), addr_t'(dc_tag));
                check_word("dc_index", addr_t'(field(c_index)), addr_t'(dc_index));
                check_word("dc_offset", addr_t'(field(c_offset)), addr_t'(dc_offset));
                check_word("dc_uncache", addr_t'(exp_va() >> 29 == 3'b101), addr_t'(dc_uncache));
                check_word("dc_op", addr_t'(field(c_op) >= 32'h7), addr_t'(dc_op));
                check_size("dc_size", size_t'(field(c_size)), dc_size);
                check_strb("dc_wstrb", strb_t'(field(c_strb)), dc_wstrb);
                if (field(c_op) >= 32'h7) begin // data only matters for stores
                    check_word("dc_wdata", field(c_wdata), dc_wdata);
                end
                check_word("s1_vpn2", exp_va() >> 13, addr_t'(s1_vpn2));
                check_word("s1_odd_page", (exp_va() >> 12) & 32'h1, addr_t'(s1_odd_page));
                check_word("s1_asid", addr_t'(entryhi_asid), addr_t'(s1_asid));
            end
            if (out_valid && ms_allowin) begin
                check_word("out_pc", field(c_pc), out_pc);
                check_word("out_dest", field(c_dest), addr_t'(out_dest));
                check_word("out_op", field(c_op), addr_t'(out_op));
                check_word("out_offset", exp_ea() & 32'h3, addr_t'(out_offset));
                check_word("out_has_exception", field(c_exc), addr_t'(out_has_exception));
                if (field(c_exc) != 0) begin
                    check_exc("out_exc_code", exc_code_t'(field(c_code)), out_exc_code);
                    check_word("out_tlb_refill", field(c_refill), addr_t'(out_tlb_refill));
                    check_word("out_badvaddr", exp_va(), out_badvaddr);
                end else if (!req_seen) begin
                    stop_on_error("instruction completed without a cache request");
                end
                done_count++;
                req_seen = 1'b0;
            end
        end
    end

    // cache and downstream responders
    always @(posedge clk) begin
        if (reset) begin
            ok_wait = 0;
            dc_addr_ok <= 1'b0;
        end else begin
            if (req_taken) begin
                ok_wait = {$random(seed)} % 4;
            end else if (ok_wait != 0) begin
                ok_wait = ok_wait - 1;
            end
            dc_addr_ok <= (ok_wait == 0);
            ms_allowin <= ({$random(seed)} % 4) != 0;
        end
    end

    initial begin
        for (int i = 0; i < max_lines*nf; i++) begin
            stim[i] = 32'hffffffff; // end marker
        end
        $readmemh(stim_path, stim);
        while (n_lines < max_lines && stim[n_lines*nf] !== 32'hffffffff) begin
            n_lines++;
        end
        if (n_lines == 0) begin
            stop_on_error("no stimulus lines found in the data file");
        end
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < n_lines; i++) begin
            if (stim[i*nf + c_twr] != 0) begin
                @(posedge clk);
                tlb_write <= 1'b1;
                @(posedge clk);
                tlb_write <= 1'b0;
            end
            @(posedge clk);
            cur = i;
            in_valid <= 1'b1;
            op       <= ls_op_t'(field(c_op));
            base     <= field(c_base);
            imm      <= 16'(field(c_imm));
            rt_value <= field(c_rt);
            dest     <= dest_w'(field(c_dest));
            pc       <= field(c_pc);
            s1_found <= 1'(field(c_found));
            s1_pfn   <= pfn_t'(field(c_pfn));
            s1_v     <= 1'(field(c_v));
            s1_d     <= 1'(field(c_d));
            entryhi_asid <= asid_t'(i);
            do @(negedge clk); while (!allowin);
            @(posedge clk);
            in_valid <= 1'b0;
            wait (done_count == i + 1);
        end
        repeat (2) @(posedge clk);
        if (done_count != n_lines) begin
            stop_on_error("more instructions reached the outputs than were sent");
        end
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        wait (n_lines > 0);
        repeat (n_lines*cycles_per_line + wd_slack) @(posedge clk);
        stop_on_error("watchdog expired, the DUT stopped finishing instructions");
    end

endmodule
